// ==== Bender.yml ====
package:
  name: mmu_mem

sources:
  - logic/mmu_pkg.sv
  - logic/atom_bus_if.sv
  - logic/mmu_pt_walk.sv
  - logic/mmu_tlb.sv
  - logic/mmu_access_port.sv
  - logic/atom_arb.sv
  - logic/atom_ram.sv
  - logic/mmu_mem_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/mmu_mem_tb.sv

// ==== logic/atom_arb.sv ====
module atom_arb import mmu_pkg::*; (
   input  logic       clkrst_mem_clk,
   input  logic       clkrst_mem_rst_n,
   atom_bus_if.arb    ptw,
   atom_bus_if.arb    acc,
   atom_bus_if.client mem
);

   logic                        acc_sel;
   logic                        ret_acc;
   // Issuing port per cycle, lined up with the memory read latency
   logic [RAM_READ_LATENCY-1:0] port_pipe_q;

   // Walker has priority
   assign acc_sel = !ptw.valid;

   assign mem.valid = ptw.valid || acc.valid;
   assign mem.opcode = acc_sel ? acc.opcode : ptw.opcode;
   assign mem.addr = acc_sel ? acc.addr : ptw.addr;
   assign mem.wdata = acc_sel ? acc.wdata : ptw.wdata;
   assign mem.wbe = acc_sel ? acc.wbe : ptw.wbe;

   assign ptw.stall = mem.stall;
   assign acc.stall = ptw.valid || mem.stall;

   assign ret_acc = port_pipe_q[RAM_READ_LATENCY-1];

   assign ptw.rvalid = mem.rvalid && !ret_acc;
   assign acc.rvalid = mem.rvalid && ret_acc;
   assign ptw.rdata = mem.rdata;
   assign acc.rdata = mem.rdata;

   // Entries for cycles with no accepted read are never looked at
   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         port_pipe_q <= '0;
      end else begin
         port_pipe_q <= {port_pipe_q[RAM_READ_LATENCY-2:0], acc_sel};
      end
   end

endmodule

// ==== logic/atom_bus_if.sv ====
interface atom_bus_if import mmu_pkg::*; ();

   // Request side, held by the client while stalled
   logic                      valid;
   atom_opc_e                 opcode;
   logic [ATOM_ADDR_BITS-1:0] addr;
   logic [ATOM_BITS-1:0]      wdata;
   logic [ATOM_BITS/8-1:0]    wbe;

   // Return side
   logic [ATOM_BITS-1:0]      rdata;
   logic                      rvalid;
   logic                      stall;

   modport client (
      output valid, opcode, addr, wdata, wbe,
      input  rdata, rvalid, stall
   );

   modport arb (
      input  valid, opcode, addr, wdata, wbe,
      output rdata, rvalid, stall
   );

endinterface

// ==== logic/atom_ram.sv ====
module atom_ram import mmu_pkg::*; (
   input  logic    clkrst_mem_clk,
   input  logic    clkrst_mem_rst_n,
   atom_bus_if.arb bus
);

   logic [ATOM_BITS-1:0]        mem_q [RAM_ATOMS];
   logic [RAM_ADDR_BITS-1:0]    idx;
   logic                        accept;
   logic                        rd_accept;
   logic                        wr_accept;
   logic [RAM_READ_LATENCY-1:0] rd_valid_q;
   logic [ATOM_BITS-1:0]        rd_data_q [RAM_READ_LATENCY];

   // Single ported, one request per cycle, never back-pressures
   assign bus.stall = 1'b0;

   // Upper atom address bits alias
   assign idx = bus.addr[RAM_ADDR_BITS-1:0];
   assign accept = bus.valid && !bus.stall;
   assign rd_accept = accept && (bus.opcode == ATOM_OPC_READ);
   assign wr_accept = accept && (bus.opcode == ATOM_OPC_WRITE);

   assign bus.rvalid = rd_valid_q[RAM_READ_LATENCY-1];
   assign bus.rdata = rd_data_q[RAM_READ_LATENCY-1];

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         rd_valid_q <= '0;
      end else begin
         rd_valid_q <= {rd_valid_q[RAM_READ_LATENCY-2:0], rd_accept};
      end
   end

   always_ff @(posedge clkrst_mem_clk) begin
      if (wr_accept) begin
         for (int b = 0; b < ATOM_BITS/8; b++) begin
            if (bus.wbe[b]) begin
               mem_q[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
            end
         end
      end
      // Read data pipeline, qualified by rd_valid_q
      rd_data_q[0] <= mem_q[idx];
      for (int s = 1; s < RAM_READ_LATENCY; s++) begin
         rd_data_q[s] <= rd_data_q[s-1];
      end
   end

endmodule

// ==== logic/mmu_access_port.sv ====
module mmu_access_port import mmu_pkg::*; (
   input  logic        clkrst_mem_clk,
   input  logic        clkrst_mem_rst_n,
   input  logic        paging_en,
   input  logic        req_valid,
   input  logic        req_write,
   input  logic [31:0] req_vaddr,
   input  logic [31:0] req_wdata,
   input  logic        lookup_done,
   input  logic [19:0] lookup_ppage,
   input  logic        lookup_fault,
   output logic        req_ready,
   output logic        rsp_valid,
   output logic [31:0] rsp_rdata,
   output logic        rsp_fault,
   output logic        lookup_valid,
   output logic [19:0] lookup_vpage,
   atom_bus_if.client  atom
);

   access_state_e state_q;
   logic          write_q;
   logic [31:0]   vaddr_q;
   logic [31:0]   wdata_q;
   logic [19:0]   ppage_q;
   logic [2:0]    word_sel;

   assign word_sel = vaddr_q[4:2];

   assign req_ready = (state_q == ACC_IDLE);
   assign lookup_valid = (state_q == ACC_TRANSLATE);
   assign lookup_vpage = vaddr_q[31:12];

   assign atom.valid = (state_q == ACC_ISSUE);
   assign atom.opcode = write_q ? ATOM_OPC_WRITE : ATOM_OPC_READ;
   assign atom.addr = {ppage_q, vaddr_q[11:5]};
   // Word replicated across the atom, byte enables pick the slot
   assign atom.wdata = {(ATOM_BITS/32){wdata_q}};

   always_comb begin
      atom.wbe = '0;
      atom.wbe[word_sel*4 +: 4] = 4'hf;
   end

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         state_q <= ACC_IDLE;
         rsp_valid <= 1'b0;
         rsp_fault <= 1'b0;
      end else begin
         rsp_valid <= 1'b0;
         case (state_q)
            ACC_IDLE: begin
               // Physical addressing skips the lookup
               if (req_valid) begin
                  state_q <= paging_en ? ACC_TRANSLATE : ACC_ISSUE;
               end
            end
            ACC_TRANSLATE: begin
               if (lookup_done) begin
                  if (lookup_fault) begin
                     rsp_valid <= 1'b1;
                     rsp_fault <= 1'b1;
                     state_q <= ACC_IDLE;
                  end else begin
                     state_q <= ACC_ISSUE;
                  end
               end
            end
            ACC_ISSUE: begin
               if (!atom.stall) begin
                  if (write_q) begin
                     rsp_valid <= 1'b1;
                     rsp_fault <= 1'b0;
                     state_q <= ACC_IDLE;
                  end else begin
                     state_q <= ACC_WAIT_READ;
                  end
               end
            end
            ACC_WAIT_READ: begin
               if (atom.rvalid) begin
                  rsp_valid <= 1'b1;
                  rsp_fault <= 1'b0;
                  state_q <= ACC_IDLE;
               end
            end
            default: state_q <= ACC_IDLE;
         endcase
      end
   end

   always_ff @(posedge clkrst_mem_clk) begin
      if (req_valid && req_ready) begin
         write_q <= req_write;
         vaddr_q <= req_vaddr;
         wdata_q <= req_wdata;
         ppage_q <= req_vaddr[31:12];
      end
      if (state_q == ACC_TRANSLATE && lookup_done) begin
         ppage_q <= lookup_ppage;
      end
      if (state_q == ACC_WAIT_READ && atom.rvalid) begin
         rsp_rdata <= atom.rdata[word_sel*32 +: 32];
      end
   end

endmodule

// ==== logic/mmu_mem_top.sv ====
module mmu_mem_top (
   input  logic        clkrst_mem_clk,
   input  logic        clkrst_mem_rst_n,
   input  logic        paging_en,
   input  logic [19:0] pagedir_base,
   input  logic        req_valid,
   input  logic        req_write,
   input  logic [31:0] req_vaddr,
   input  logic [31:0] req_wdata,
   output logic        req_ready,
   output logic        rsp_valid,
   output logic [31:0] rsp_rdata,
   output logic        rsp_fault
);

   logic        lookup_valid;
   logic [19:0] lookup_vpage;
   logic        lookup_done;
   logic [19:0] lookup_ppage;
   logic        lookup_fault;

   // Walker side, access side and the shared memory side
   atom_bus_if ptw_bus ();
   atom_bus_if acc_bus ();
   atom_bus_if mem_bus ();

   mmu_access_port u_access_port (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .paging_en        (paging_en),
      .req_valid        (req_valid),
      .req_write        (req_write),
      .req_vaddr        (req_vaddr),
      .req_wdata        (req_wdata),
      .lookup_done      (lookup_done),
      .lookup_ppage     (lookup_ppage),
      .lookup_fault     (lookup_fault),
      .req_ready        (req_ready),
      .rsp_valid        (rsp_valid),
      .rsp_rdata        (rsp_rdata),
      .rsp_fault        (rsp_fault),
      .lookup_valid     (lookup_valid),
      .lookup_vpage     (lookup_vpage),
      .atom             (acc_bus)
   );

   mmu_tlb u_tlb (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .lookup_valid     (lookup_valid),
      .lookup_vpage     (lookup_vpage),
      .pagedir_base     (pagedir_base),
      .paging_en        (paging_en),
      .lookup_done      (lookup_done),
      .lookup_ppage     (lookup_ppage),
      .lookup_fault     (lookup_fault),
      .atom             (ptw_bus)
   );

   atom_arb u_arb (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .ptw              (ptw_bus),
      .acc              (acc_bus),
      .mem              (mem_bus)
   );

   atom_ram u_ram (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .bus              (mem_bus)
   );

endmodule

// ==== logic/mmu_pkg.sv ====
package mmu_pkg;

   // Memory atom geometry
   localparam int ATOM_BITS = 256;
   localparam int ATOM_ADDR_BITS = 27;

   // On-chip atom memory standing in for the L2 cache
   localparam int RAM_ATOMS = 1024;
   localparam int RAM_ADDR_BITS = $clog2(RAM_ATOMS);
   localparam int RAM_READ_LATENCY = 2;

   // Translation cache size
   localparam int TLB_ENTRIES = 4;
   localparam int TLB_IDX_BITS = $clog2(TLB_ENTRIES);

   typedef enum logic [2:0] {
      ATOM_OPC_READ  = 3'b000,
      ATOM_OPC_WRITE = 3'b001
   } atom_opc_e;

   typedef enum logic [2:0] {
      PTW_IDLE,
      PTW_BEGIN_READ_DIR,
      PTW_READ_DIR,
      PTW_BEGIN_READ_TAB,
      PTW_READ_TAB
   } ptw_state_e;

   typedef enum logic [1:0] {
      ACC_IDLE,
      ACC_TRANSLATE,
      ACC_ISSUE,
      ACC_WAIT_READ
   } access_state_e;

endpackage

// ==== logic/mmu_pt_walk.sv ====
module mmu_pt_walk import mmu_pkg::*; (
   input  logic        clkrst_mem_clk,
   input  logic        clkrst_mem_rst_n,
   input  logic [19:0] tlb2ptw_addr,
   input  logic        tlb2ptw_re,
   input  logic [19:0] ptw_pagedir_base,
   output logic [19:0] tlb2ptw_phys_addr,
   output logic        tlb2ptw_ready,
   output logic [3:0]  tlb2ptw_pagetab_flags,
   output logic [3:0]  tlb2ptw_pagedir_flags,
   atom_bus_if.client  atom
);

   ptw_state_e                state_q;
   logic                      valid_q;
   logic [ATOM_ADDR_BITS-1:0] addr_q;

   logic [9:0]                dir_idx;
   logic [9:0]                tab_idx;
   logic [31:0]               dir_entry;
   logic [31:0]               tab_entry;

   logic [3:0]                dir_flags_q;
   logic [19:0]               tab_ppage_q;
   logic [3:0]                tab_flags_q;

   assign dir_idx = tlb2ptw_addr[19:10];
   assign tab_idx = tlb2ptw_addr[9:0];

   // Eight entries per atom, picked by the low three index bits
   assign dir_entry = atom.rdata[{dir_idx[2:0], 5'b00000} +: 32];
   assign tab_entry = atom.rdata[{tab_idx[2:0], 5'b00000} +: 32];

   // The walker only ever reads
   assign atom.valid = valid_q;
   assign atom.opcode = ATOM_OPC_READ;
   assign atom.addr = addr_q;
   assign atom.wdata = '0;
   assign atom.wbe = '0;

   assign tlb2ptw_ready = (state_q == PTW_IDLE);
   assign tlb2ptw_pagedir_flags = dir_flags_q;
   assign tlb2ptw_pagetab_flags = tab_flags_q;
   assign tlb2ptw_phys_addr = tab_ppage_q;

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         state_q <= PTW_IDLE;
         valid_q <= 1'b0;
      end else begin
         case (state_q)
            PTW_IDLE: begin
               if (tlb2ptw_re) begin
                  valid_q <= 1'b1;
                  state_q <= PTW_BEGIN_READ_DIR;
               end
            end
            PTW_BEGIN_READ_DIR: begin
               if (!atom.stall) begin
                  valid_q <= 1'b0;
                  state_q <= PTW_READ_DIR;
               end
            end
            PTW_READ_DIR: begin
               if (atom.rvalid) begin
                  if (dir_entry[0]) begin
                     valid_q <= 1'b1;
                     state_q <= PTW_BEGIN_READ_TAB;
                  end else begin
                     state_q <= PTW_IDLE;
                  end
               end
            end
            PTW_BEGIN_READ_TAB: begin
               if (!atom.stall) begin
                  valid_q <= 1'b0;
                  state_q <= PTW_READ_TAB;
               end
            end
            PTW_READ_TAB: begin
               if (atom.rvalid) begin
                  state_q <= PTW_IDLE;
               end
            end
            default: state_q <= PTW_IDLE;
         endcase
      end
   end

   always_ff @(posedge clkrst_mem_clk) begin
      if (state_q == PTW_IDLE && tlb2ptw_re) begin
         addr_q <= {ptw_pagedir_base, dir_idx[9:3]};
      end
      if (state_q == PTW_READ_DIR && atom.rvalid) begin
         dir_flags_q <= dir_entry[3:0];
         // Zero table entry means fault unless the table read replaces it
         tab_ppage_q <= '0;
         tab_flags_q <= '0;
         addr_q <= {dir_entry[31:12], tab_idx[9:3]};
      end
      if (state_q == PTW_READ_TAB && atom.rvalid) begin
         tab_ppage_q <= tab_entry[31:12];
         tab_flags_q <= tab_entry[3:0];
      end
   end

endmodule

// ==== logic/mmu_tlb.sv ====
module mmu_tlb import mmu_pkg::*; (
   input  logic        clkrst_mem_clk,
   input  logic        clkrst_mem_rst_n,
   input  logic        lookup_valid,
   input  logic [19:0] lookup_vpage,
   input  logic [19:0] pagedir_base,
   input  logic        paging_en,
   output logic        lookup_done,
   output logic [19:0] lookup_ppage,
   output logic        lookup_fault,
   atom_bus_if.client  atom
);

   logic [19:0]             tag_q [TLB_ENTRIES];
   logic [19:0]             ppage_q [TLB_ENTRIES];
   logic [TLB_ENTRIES-1:0]  valid_q;
   logic [TLB_IDX_BITS-1:0] victim_q;
   logic                    walking_q;

   logic                    ptw_re;
   logic [19:0]             ptw_ppage;
   logic                    ptw_ready;
   logic [3:0]              ptw_tab_flags;
   logic [3:0]              ptw_dir_flags;

   logic                    hit;
   logic [19:0]             hit_ppage;
   logic                    start;
   logic                    walk_done;
   logic                    walk_ok;

   // Fully associative compare against every valid entry
   always_comb begin
      hit = 1'b0;
      hit_ppage = '0;
      for (int i = 0; i < TLB_ENTRIES; i++) begin
         if (valid_q[i] && tag_q[i] == lookup_vpage) begin
            hit = 1'b1;
            hit_ppage = ppage_q[i];
         end
      end
   end

   // The requester keeps lookup_valid up through the done cycle
   assign start = lookup_valid && !lookup_done && !walking_q;
   // Ready is still high in the cycle re is seen, so skip that one
   assign walk_done = walking_q && !ptw_re && ptw_ready;
   assign walk_ok = ptw_dir_flags[0] && ptw_tab_flags[0];

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         valid_q <= '0;
         victim_q <= '0;
         walking_q <= 1'b0;
         ptw_re <= 1'b0;
         lookup_done <= 1'b0;
      end else begin
         lookup_done <= 1'b0;
         ptw_re <= 1'b0;
         if (!paging_en) begin
            valid_q <= '0;
         end else if (walk_done && walk_ok) begin
            valid_q[victim_q] <= 1'b1;
            victim_q <= victim_q + 1'b1;
         end
         if (start) begin
            if (hit) begin
               lookup_done <= 1'b1;
            end else begin
               ptw_re <= 1'b1;
               walking_q <= 1'b1;
            end
         end
         if (walk_done) begin
            walking_q <= 1'b0;
            lookup_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clkrst_mem_clk) begin
      if (start && hit) begin
         lookup_ppage <= hit_ppage;
         lookup_fault <= 1'b0;
      end
      if (walk_done) begin
         lookup_ppage <= ptw_ppage;
         lookup_fault <= !walk_ok;
         // Only complete, present translations are cached
         if (walk_ok) begin
            tag_q[victim_q] <= lookup_vpage;
            ppage_q[victim_q] <= ptw_ppage;
         end
      end
   end

   mmu_pt_walk u_pt_walk (
      .clkrst_mem_clk        (clkrst_mem_clk),
      .clkrst_mem_rst_n      (clkrst_mem_rst_n),
      .tlb2ptw_addr          (lookup_vpage),
      .tlb2ptw_re            (ptw_re),
      .ptw_pagedir_base      (pagedir_base),
      .tlb2ptw_phys_addr     (ptw_ppage),
      .tlb2ptw_ready         (ptw_ready),
      .tlb2ptw_pagetab_flags (ptw_tab_flags),
      .tlb2ptw_pagedir_flags (ptw_dir_flags),
      .atom                  (atom)
   );

endmodule

// ==== tests/mmu_mem_tb.sv ====
module mmu_mem_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          TIMEOUT_CYCLES = 200;
   localparam logic [19:0] DIR_PAGE = 20'd0;
   localparam logic [9:0]  DIR_A = 10'd1;
   localparam logic [9:0]  DIR_B = 10'd2;
   localparam logic [9:0]  DIR_NP = 10'd3;

   logic        clkrst_mem_clk;
   logic        clkrst_mem_rst_n;
   logic        paging_en;
   logic [19:0] pagedir_base;
   logic        req_valid;
   logic        req_write;
   logic [31:0] req_vaddr;
   logic [31:0] req_wdata;
   logic        req_ready;
   logic        rsp_valid;
   logic [31:0] rsp_rdata;
   logic        rsp_fault;

   // Expected response of the request in flight
   logic        exp_fault;
   logic        exp_read;
   logic [31:0] exp_rdata;
   logic        pending;
   logic [31:0] lfsr_q;

   // Sparse word memory indexed by physical word address
   logic [31:0] mem_model [int];
   logic [19:0] vpage [5];
   logic [11:0] va_off [5];

   tb_clock u_tb_clock (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n)
   );

   mmu_mem_top u_mmu_mem_top (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .paging_en        (paging_en),
      .pagedir_base     (pagedir_base),
      .req_valid        (req_valid),
      .req_write        (req_write),
      .req_vaddr        (req_vaddr),
      .req_wdata        (req_wdata),
      .req_ready        (req_ready),
      .rsp_valid        (rsp_valid),
      .rsp_rdata        (rsp_rdata),
      .rsp_fault        (rsp_fault)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                  input logic [31:0] actual);
      fail_run($sformatf("Mismatch at %0d ns: %s expected %h, got %h",
                         $time, sig, expected, actual));
   endtask

   fault_check: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      rsp_valid |-> rsp_fault == exp_fault)
      else report_mismatch("rsp_fault", $sampled(exp_fault), $sampled(rsp_fault));

   rdata_check: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      rsp_valid && exp_read && !exp_fault |-> rsp_rdata == exp_rdata)
      else report_mismatch("rsp_rdata", $sampled(exp_rdata), $sampled(rsp_rdata));

   rsp_owner_check: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      rsp_valid |-> pending)
      else fail_run("rsp_valid pulsed with no request outstanding");

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         bits = {bits[30:0], fb};
      end
      return bits;
   endfunction

   // Page bits above 2 alias in the 32 KiB RAM
   function automatic int word_index(input logic [19:0] page, input logic [11:0] offset);
      return int'({page[2:0], offset[11:2]});
   endfunction

   function automatic logic [31:0] model_word(input int idx);
      return mem_model.exists(idx) ? mem_model[idx] : 32'h0;
   endfunction

   // Two-level walk over the model memory on the present bit only
   function automatic void walk_model(input logic [31:0] vaddr, output logic fault,
                                      output logic [19:0] ppage);
      logic [31:0] dir_entry;
      logic [31:0] tab_entry;
      dir_entry = model_word(word_index(DIR_PAGE, {vaddr[31:22], 2'b00}));
      tab_entry = 32'h0;
      if (dir_entry[0]) begin
         tab_entry = model_word(word_index(dir_entry[31:12], {vaddr[21:12], 2'b00}));
      end
      fault = !tab_entry[0];
      ppage = tab_entry[31:12];
   endfunction

   task automatic do_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic fault,
                            input logic [31:0] rdata);
      int cycles;
      exp_fault = fault;
      exp_read = !write;
      exp_rdata = rdata;
      @(posedge clkrst_mem_clk);
      req_valid <= 1'b1;
      req_write <= write;
      req_vaddr <= addr;
      req_wdata <= wdata;
      cycles = 0;
      do begin
         @(posedge clkrst_mem_clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) fail_run("Timed out waiting for req_ready");
      end while (!req_ready);
      req_valid <= 1'b0;
      pending = 1'b1;
      cycles = 0;
      do begin
         @(posedge clkrst_mem_clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) fail_run("Timed out waiting for rsp_valid");
      end while (!rsp_valid);
      pending = 1'b0;
   endtask

   task automatic mapped_access(input logic write, input logic [31:0] vaddr,
                                input logic [31:0] wdata, input logic fault,
                                input logic [19:0] ppage);
      int idx;
      idx = word_index(ppage, vaddr[11:0]);
      if (fault) begin
         do_access(write, vaddr, wdata, 1'b1, 32'h0);
      end else if (write) begin
         do_access(1'b1, vaddr, wdata, 1'b0, 32'h0);
         mem_model[idx] = wdata;
      end else if (!mem_model.exists(idx)) begin
         fail_run("Read targets a word that was never written");
      end else begin
         do_access(1'b0, vaddr, 32'h0, 1'b0, mem_model[idx]);
      end
   endtask

   task automatic virt_access(input logic write, input logic [31:0] vaddr,
                              input logic [31:0] wdata);
      logic        fault;
      logic [19:0] ppage;
      walk_model(vaddr, fault, ppage);
      mapped_access(write, vaddr, wdata, fault, ppage);
   endtask

   task automatic phys_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata);
      mapped_access(write, addr, wdata, 1'b0, addr[31:12]);
   endtask

   task automatic set_paging(input logic en);
      @(posedge clkrst_mem_clk);
      paging_en <= en;
   endtask

   initial begin
      logic [31:0] addr_list [8];
      logic [31:0] rnd;
      logic [9:0]  tab_idx;
      logic [19:0] vp_w;
      logic [19:0] vp_f1;
      logic [19:0] vp_f2;
      logic        fault;
      logic [19:0] old_ppage;
      int          cycles;

      paging_en = 1'b0;
      pagedir_base = DIR_PAGE;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_vaddr = 32'h0;
      req_wdata = 32'h0;
      exp_fault = 1'b0;
      exp_read = 1'b0;
      exp_rdata = 32'h0;
      pending = 1'b0;
      lfsr_q = 32'h19a9d57f;

      cycles = 0;
      while (clkrst_mem_rst_n !== 1'b1) begin
         @(posedge clkrst_mem_clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) fail_run("Reset never released");
      end
      @(posedge clkrst_mem_clk);
      if (!req_ready) fail_run("req_ready is low after reset");

      // Physical writes and read-back
      for (int i = 0; i < 8; i++) begin
         rnd = lfsr_bits(13);
         addr_list[i] = {17'd0, rnd[12:0], 2'b00};
         phys_access(1'b1, addr_list[i], lfsr_bits(32));
      end
      for (int i = 0; i < 8; i++) begin
         phys_access(1'b0, addr_list[i], 32'h0);
      end

      // Directory at page 0, tables at pages 1 and 2, data at pages 3 to 7
      phys_access(1'b1, {DIR_PAGE, DIR_A, 2'b00}, 32'h0000_1001);
      phys_access(1'b1, {DIR_PAGE, DIR_B, 2'b00}, 32'h0000_2005);
      phys_access(1'b1, {DIR_PAGE, DIR_NP, 2'b00}, 32'h0000_2000);
      for (int k = 0; k < 5; k++) begin
         rnd = lfsr_bits(7);
         tab_idx = {rnd[6:0], 3'(k)};
         vpage[k] = {(k < 3) ? DIR_A : DIR_B, tab_idx};
         rnd = lfsr_bits(7);
         va_off[k] = {rnd[6:0], 5'd0};
         rnd = lfsr_bits(3);
         phys_access(1'b1, {(k < 3) ? 20'd1 : 20'd2, tab_idx, 2'b00},
                     {20'(3 + k), 8'h00, rnd[2:0], 1'b1});
         for (int w = 0; w < 8; w++) begin
            phys_access(1'b1, {20'(3 + k), va_off[k] + 12'(4 * w)}, lfsr_bits(32));
         end
      end
      // Window onto table page 1 and a table entry with present clear
      rnd = lfsr_bits(7);
      tab_idx = {rnd[6:0], 3'd5};
      vp_w = {DIR_B, tab_idx};
      phys_access(1'b1, {20'd2, tab_idx, 2'b00}, 32'h0000_1003);
      rnd = lfsr_bits(7);
      tab_idx = {rnd[6:0], 3'd6};
      vp_f2 = {DIR_B, tab_idx};
      phys_access(1'b1, {20'd2, tab_idx, 2'b00}, 32'h0000_500e);
      rnd = lfsr_bits(10);
      vp_f1 = {DIR_NP, rnd[9:0]};

      // Virtual reads over five pages and a revisit in reverse
      set_paging(1'b1);
      for (int k = 0; k < 5; k++) begin
         for (int w = 0; w < 8; w++) begin
            virt_access(1'b0, {vpage[k], va_off[k] + 12'(4 * w)}, 32'h0);
         end
      end
      for (int k = 4; k >= 0; k--) begin
         virt_access(1'b0, {vpage[k], va_off[k] + 12'd12}, 32'h0);
      end

      // Virtual write checked through physical reads of the whole atom
      virt_access(1'b1, {vpage[1], va_off[1] + 12'd12}, lfsr_bits(32));
      set_paging(1'b0);
      for (int w = 0; w < 8; w++) begin
         phys_access(1'b0, {20'd4, va_off[1] + 12'(4 * w)}, 32'h0);
      end

      // Faults leave memory alone
      phys_access(1'b1, {20'd0, 12'h100}, lfsr_bits(32));
      phys_access(1'b1, {20'd5, 12'h100}, lfsr_bits(32));
      phys_access(1'b1, {20'd5, 12'h104}, lfsr_bits(32));
      set_paging(1'b1);
      virt_access(1'b1, {vp_f1, 12'h100}, lfsr_bits(32));
      virt_access(1'b0, {vp_f2, 12'h100}, 32'h0);
      virt_access(1'b1, {vp_f2, 12'h104}, lfsr_bits(32));
      set_paging(1'b0);
      phys_access(1'b0, {20'd0, 12'h100}, 32'h0);
      phys_access(1'b0, {20'd5, 12'h100}, 32'h0);
      phys_access(1'b0, {20'd5, 12'h104}, 32'h0);
      phys_access(1'b0, {20'd2, vp_f2[9:0], 2'b00}, 32'h0);

      // Stale translation until paging is toggled
      set_paging(1'b1);
      virt_access(1'b0, {vpage[0], va_off[0]}, 32'h0);
      walk_model({vpage[0], 12'h000}, fault, old_ppage);
      virt_access(1'b1, {vp_w, vpage[0][9:0], 2'b00}, 32'h0000_7001);
      mapped_access(1'b0, {vpage[0], va_off[0]}, 32'h0, fault, old_ppage);
      set_paging(1'b0);
      set_paging(1'b1);
      for (int w = 0; w < 8; w++) begin
         virt_access(1'b0, {vpage[0], va_off[4] + 12'(4 * w)}, 32'h0);
      end

      repeat (4) @(posedge clkrst_mem_clk);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
   output logic clkrst_mem_clk,
   output logic clkrst_mem_rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   // 4 ns period
   initial begin
      clkrst_mem_clk = 1'b0;
      forever #2 clkrst_mem_clk = ~clkrst_mem_clk;
   end

   // Reset held low for ten rising edges
   initial begin
      clkrst_mem_rst_n = 1'b0;
      repeat (10) @(posedge clkrst_mem_clk);
      clkrst_mem_rst_n <= 1'b1;
   end

endmodule

// ==== vlog.f ====
logic/mmu_pkg.sv
logic/atom_bus_if.sv
logic/mmu_pt_walk.sv
logic/mmu_tlb.sv
logic/mmu_access_port.sv
logic/atom_arb.sv
logic/atom_ram.sv
logic/mmu_mem_top.sv
tests/tb_clock.sv
tests/mmu_mem_tb.sv
